// ==== Bender.yml ====
package:
  name: feature_core

sources:
  - hw/feature_pkg.sv
  - hw/row_mem.sv
  - hw/line_buffer.sv
  - hw/gaussian_blur.sv
  - hw/keypoint_detect.sv
  - hw/feature_ctrl.sv
  - hw/feature_core.sv
  - target: test
    files:
      - tests/tb_feature_core.sv

// ==== flist.f ====
hw/feature_pkg.sv
hw/row_mem.sv
hw/line_buffer.sv
hw/gaussian_blur.sv
hw/keypoint_detect.sv
hw/feature_ctrl.sv
hw/feature_core.sv
tests/tb_feature_core.sv

// ==== hw/feature_core.sv ====
module feature_core
    import feature_pkg::*;
#(
    parameter int kpt_depth = KPT_DEPTH_DEF
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  pix_t                           threshold,
    input  logic                           img_we,
    input  row_addr_t                      img_addr,
    input  pix_row_t                       img_din,
    input  logic [$clog2(kpt_depth)-1:0]   kpt_rd_addr,
    output kpt_entry_t                     kpt_dout,
    output logic [$clog2(kpt_depth+1)-1:0] kpt_count,
    output logic                           busy,
    output logic                           done
);

    logic                         blur_start;
    logic                         blur_done;
    logic                         detect_start;
    logic                         detect_done;
    row_addr_t                    img_mem_addr;
    logic                         img_mem_we;
    pix_row_t                     img_dout;
    row_addr_t                    blur_img_addr;
    logic                         blur_we;
    row_addr_t                    blur_wr_addr;
    row_addr_t                    blur_mem_addr;
    pix_row_t                     blur_din;
    pix_row_t                     blur_dout;
    row_addr_t                    det_row_addr;
    logic                         det_kpt_we;
    logic [$clog2(kpt_depth)-1:0] det_kpt_addr;
    kpt_entry_t                   det_kpt_din;
    logic [$clog2(kpt_depth)-1:0] kpt_mem_addr;
    logic                         kpt_mem_we;

    assign blur_mem_addr = blur_we ? blur_wr_addr : det_row_addr;   // detect reads between writes

    feature_ctrl #(
        .kpt_depth (kpt_depth)
    ) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .img_we_ext    (img_we),
        .img_addr_ext  (img_addr),
        .kpt_rd_addr   (kpt_rd_addr),
        .blur_done     (blur_done),
        .detect_done   (detect_done),
        .blur_img_addr (blur_img_addr),
        .det_img_addr  (det_row_addr),
        .det_kpt_addr  (det_kpt_addr),
        .det_kpt_we    (det_kpt_we),
        .blur_start    (blur_start),
        .detect_start  (detect_start),
        .img_mem_addr  (img_mem_addr),
        .img_mem_we    (img_mem_we),
        .kpt_mem_addr  (kpt_mem_addr),
        .kpt_mem_we    (kpt_mem_we),
        .busy          (busy),
        .done          (done)
    );

    gaussian_blur u_blur (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (blur_start),
        .img_dout  (img_dout),
        .img_addr  (blur_img_addr),
        .blur_we   (blur_we),
        .blur_addr (blur_wr_addr),
        .blur_din  (blur_din),
        .done      (blur_done)
    );

    keypoint_detect #(
        .kpt_depth (kpt_depth)
    ) u_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (detect_start),
        .threshold (threshold),
        .img_dout  (img_dout),
        .blur_dout (blur_dout),
        .row_addr  (det_row_addr),
        .kpt_we    (det_kpt_we),
        .kpt_addr  (det_kpt_addr),
        .kpt_din   (det_kpt_din),
        .kpt_count (kpt_count),
        .done      (detect_done)
    );

    row_mem #(
        .depth  (IMG_ROWS),
        .word_t (pix_row_t)
    ) u_img_mem (
        .clk  (clk),
        .we   (img_mem_we),
        .addr (img_mem_addr),
        .din  (img_din),
        .dout (img_dout)
    );

    row_mem #(
        .depth  (IMG_ROWS),
        .word_t (pix_row_t)
    ) u_blur_mem (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_mem_addr),
        .din  (blur_din),
        .dout (blur_dout)
    );

    row_mem #(
        .depth  (kpt_depth),
        .word_t (kpt_entry_t)
    ) u_kpt_mem (
        .clk  (clk),
        .we   (kpt_mem_we),
        .addr (kpt_mem_addr),
        .din  (det_kpt_din),
        .dout (kpt_dout)
    );

endmodule

// ==== hw/feature_ctrl.sv ====
module feature_ctrl
    import feature_pkg::*;
#(
    parameter int kpt_depth = KPT_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         img_we_ext,
    input  row_addr_t                    img_addr_ext,
    input  logic [$clog2(kpt_depth)-1:0] kpt_rd_addr,
    input  logic                         blur_done,
    input  logic                         detect_done,
    input  row_addr_t                    blur_img_addr,
    input  row_addr_t                    det_img_addr,
    input  logic [$clog2(kpt_depth)-1:0] det_kpt_addr,
    input  logic                         det_kpt_we,
    output logic                         blur_start,
    output logic                         detect_start,
    output row_addr_t                    img_mem_addr,
    output logic                         img_mem_we,
    output logic [$clog2(kpt_depth)-1:0] kpt_mem_addr,
    output logic                         kpt_mem_we,
    output logic                         busy,
    output logic                         done
);

    phase_t phase;

    assign busy = (phase != PH_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= PH_IDLE;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            done         <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase      <= PH_BLUR;
                        blur_start <= 1'b1;
                    end
                end
                PH_BLUR: begin
                    if (blur_done) begin
                        phase        <= PH_DETECT;
                        detect_start <= 1'b1;
                    end
                end
                PH_DETECT: begin
                    if (detect_done) begin
                        phase <= PH_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // memory port steering per phase
    always_comb begin
        img_mem_addr = img_addr_ext;
        img_mem_we   = 1'b0;
        kpt_mem_addr = kpt_rd_addr;
        kpt_mem_we   = 1'b0;
        case (phase)
            PH_IDLE: begin
                img_mem_we = img_we_ext;   // image load only while idle
            end
            PH_BLUR: begin
                img_mem_addr = blur_img_addr;
            end
            PH_DETECT: begin
                img_mem_addr = det_img_addr;
                kpt_mem_addr = det_kpt_addr;
                kpt_mem_we   = det_kpt_we;
            end
            default: begin
                img_mem_addr = '0;
                kpt_mem_addr = '0;
            end
        endcase
    end

endmodule

// ==== hw/feature_pkg.sv ====
package feature_pkg;

    localparam int IMG_ROWS      = 16;
    localparam int IMG_COLS      = 16;
    localparam int PIX_W         = 8;
    localparam int KPT_DEPTH_DEF = 64;   // default keypoint memory depth

    typedef logic [PIX_W-1:0] pix_t;

    // pixel c sits at bits [c*PIX_W +: PIX_W]
    typedef logic [IMG_COLS*PIX_W-1:0] pix_row_t;

    typedef logic [$clog2(IMG_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(IMG_COLS)-1:0] col_t;

    typedef struct packed {
        row_addr_t row;   // upper nibble
        col_t      col;
    } kpt_entry_t;

    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_BLUR   = 2'd1,
        PH_DETECT = 2'd2
    } phase_t;

endpackage

// ==== hw/gaussian_blur.sv ====
module gaussian_blur
    import feature_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  pix_row_t  img_dout,
    output row_addr_t img_addr,
    output logic      blur_we,
    output row_addr_t blur_addr,
    output pix_row_t  blur_din,
    output logic      done
);

    localparam int SH_W = $clog2(IMG_ROWS + 2);

    logic            rd_active;
    row_addr_t       rd_row;
    logic            rd_vld;
    logic            rd_last;
    logic            zero_shift;
    logic            shift;
    logic            win_vld;
    logic [SH_W-1:0] sh_cnt;   // rows shifted into the window
    pix_row_t        row_above;
    pix_row_t        row_mid;
    pix_row_t        row_below;
    logic [9:0]      vsum [IMG_COLS];

    assign img_addr = rd_row;
    assign shift    = rd_vld | zero_shift;

    // window is cleared together with the pass start
    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n & ~start),
        .shift     (shift),
        .fill_zero (zero_shift),
        .row_in    (img_dout),
        .row_above (row_above),
        .row_mid   (row_mid),
        .row_below (row_below)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active  <= 1'b0;
            rd_row     <= '0;
            rd_vld     <= 1'b0;
            rd_last    <= 1'b0;
            zero_shift <= 1'b0;
            win_vld    <= 1'b0;
            sh_cnt     <= '0;
            done       <= 1'b0;
        end else begin
            rd_vld     <= rd_active;
            rd_last    <= rd_active && rd_row == row_addr_t'(IMG_ROWS - 1);
            zero_shift <= rd_last;   // one extra shift below the last row
            win_vld    <= shift;
            done       <= win_vld && sh_cnt == SH_W'(IMG_ROWS + 1);
            if (start) begin
                rd_active <= 1'b1;
                rd_row    <= '0;
                sh_cnt    <= '0;
            end else begin
                if (rd_active) begin
                    rd_row <= rd_row + 1'b1;
                    if (rd_row == row_addr_t'(IMG_ROWS - 1)) begin
                        rd_active <= 1'b0;
                    end
                end
                if (shift) begin
                    sh_cnt <= sh_cnt + 1'b1;
                end
            end
        end
    end

    // mid row is complete once the row below it has arrived
    assign blur_we   = win_vld && sh_cnt >= SH_W'(2);
    assign blur_addr = row_addr_t'(sh_cnt - SH_W'(2));

    always_comb begin
        for (int c = 0; c < IMG_COLS; c++) begin
            vsum[c] = {2'b00, row_above[c*PIX_W +: PIX_W]}
                    + {1'b0, row_mid[c*PIX_W +: PIX_W], 1'b0}
                    + {2'b00, row_below[c*PIX_W +: PIX_W]};
        end
    end

    always_comb begin
        logic [11:0] hsum;
        for (int c = 0; c < IMG_COLS; c++) begin
            hsum = {1'b0, vsum[c], 1'b0};
            if (c > 0) begin
                hsum = hsum + {2'b00, vsum[c-1]};
            end
            if (c < IMG_COLS - 1) begin
                hsum = hsum + {2'b00, vsum[c+1]};
            end
            blur_din[c*PIX_W +: PIX_W] = hsum[11:4];   // divide by 16
        end
    end

endmodule

// ==== hw/keypoint_detect.sv ====
module keypoint_detect
    import feature_pkg::*;
#(
    parameter int kpt_depth = KPT_DEPTH_DEF
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  pix_t                             threshold,
    input  pix_row_t                         img_dout,
    input  pix_row_t                         blur_dout,
    output row_addr_t                        row_addr,
    output logic                             kpt_we,
    output logic [$clog2(kpt_depth)-1:0]     kpt_addr,
    output kpt_entry_t                       kpt_din,
    output logic [$clog2(kpt_depth+1)-1:0]   kpt_count,
    output logic                             done
);

    localparam int CNT_W = $clog2(kpt_depth + 1);

    logic      rd;     // rows arrive from both memories
    logic      scan;
    row_addr_t cur_row;
    col_t      cur_col;
    pix_row_t  img_q;
    pix_row_t  blur_q;
    pix_t      pix;
    pix_t      blur_pix;
    pix_t      diff;
    logic      last_col;

    assign pix      = img_q[cur_col*PIX_W +: PIX_W];
    assign blur_pix = blur_q[cur_col*PIX_W +: PIX_W];
    assign diff     = (pix > blur_pix) ? pix - blur_pix : blur_pix - pix;
    assign last_col = scan && cur_col == col_t'(IMG_COLS - 1);

    assign kpt_we   = scan && diff > threshold && kpt_count < CNT_W'(kpt_depth);
    assign kpt_addr = kpt_count[$clog2(kpt_depth)-1:0];
    assign kpt_din  = '{row: cur_row, col: cur_col};

    // next row is addressed during the last column so it is ready one cycle later
    assign row_addr = start    ? '0 :
                      last_col ? row_addr_t'(cur_row + 1'b1) : cur_row;

    always_ff @(posedge clk) begin
        if (rd) begin
            img_q  <= img_dout;
            blur_q <= blur_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd        <= 1'b0;
            scan      <= 1'b0;
            cur_row   <= '0;
            cur_col   <= '0;
            kpt_count <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                rd        <= 1'b1;
                scan      <= 1'b0;
                cur_row   <= '0;
                kpt_count <= '0;
            end else if (rd) begin
                rd      <= 1'b0;
                scan    <= 1'b1;
                cur_col <= '0;
            end else if (scan) begin
                if (kpt_we) begin
                    kpt_count <= kpt_count + 1'b1;   // stops at kpt_depth
                end
                cur_col <= cur_col + 1'b1;
                if (last_col) begin
                    scan <= 1'b0;
                    if (cur_row == row_addr_t'(IMG_ROWS - 1)) begin
                        done <= 1'b1;
                    end else begin
                        cur_row <= cur_row + 1'b1;
                        rd      <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/line_buffer.sv ====
module line_buffer
    import feature_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     shift,
    input  logic     fill_zero,
    input  pix_row_t row_in,
    output pix_row_t row_above,
    output pix_row_t row_mid,
    output pix_row_t row_below
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_above <= '0;
            row_mid   <= '0;
            row_below <= '0;
        end else if (shift) begin
            row_above <= row_mid;
            row_mid   <= row_below;
            row_below <= fill_zero ? '0 : row_in;   // zero row past the bottom edge
        end
    end

endmodule

// ==== hw/row_mem.sv ====
module row_mem #(
    parameter int  depth  = 16,
    parameter type word_t = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  word_t                    din,
    output word_t                    dout
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];   // old data on same-address write
    end

endmodule

// ==== tests/tb_feature_core.sv ====
module tb_feature_core
    import feature_pkg::*;
();

    localparam int          CLK_PERIOD  = 4;
    localparam int          KPT_DEPTH   = KPT_DEPTH_DEF;
    localparam logic [31:0] LFSR_SEED   = 32'h2e0b_338e;
    localparam int          NUM_RUNS    = 5;
    localparam int          RUN_CYCLES  = IMG_ROWS * (IMG_COLS + 8) + 40;
    localparam int          LOAD_CYCLES = 2 * IMG_ROWS + 2 * KPT_DEPTH + 40;   // load + readout
    localparam int          LIMIT       = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES) + 40;

    typedef logic [$clog2(KPT_DEPTH+1)-1:0] count_t;
    typedef logic [$clog2(KPT_DEPTH)-1:0]   kaddr_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    pix_t       threshold;
    logic       img_we;
    row_addr_t  img_addr;
    pix_row_t   img_din;
    kaddr_t     kpt_rd_addr;
    kpt_entry_t kpt_dout;
    count_t     kpt_count;
    logic       busy;
    logic       done;

    logic        check_req;
    logic [31:0] lfsr_state;
    pix_t        img [IMG_ROWS][IMG_COLS];   // copy of the loaded image
    kpt_entry_t  exp_q [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    feature_core #(
        .kpt_depth (KPT_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .threshold   (threshold),
        .img_we      (img_we),
        .img_addr    (img_addr),
        .img_din     (img_din),
        .kpt_rd_addr (kpt_rd_addr),
        .kpt_dout    (kpt_dout),
        .kpt_count   (kpt_count),
        .busy        (busy),
        .done        (done)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    // mostly dim pixels with a rare bright spike
    function automatic pix_t sparse_pixel();
        if (random_bits(6) == 0) begin
            return pix_t'(8'h80 | random_bits(7));
        end
        return pix_t'(random_bits(5));
    endfunction

    function automatic pix_row_t random_row();
        pix_row_t row;
        for (int c = 0; c < IMG_COLS; c++) begin
            row[c*PIX_W +: PIX_W] = pix_t'(random_bits(PIX_W));
        end
        return row;
    endfunction

    function automatic pix_row_t pack_row(input int r);
        pix_row_t row;
        for (int c = 0; c < IMG_COLS; c++) begin
            row[c*PIX_W +: PIX_W] = img[r][c];
        end
        return row;
    endfunction

    function automatic pix_t blur_pixel(input int r, input int c);
        int sum;
        int wr;
        int wc;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (r + dr >= 0 && r + dr < IMG_ROWS && c + dc >= 0 && c + dc < IMG_COLS) begin
                    wr  = (dr == 0) ? 2 : 1;
                    wc  = (dc == 0) ? 2 : 1;
                    sum = sum + wr * wc * int'(img[r+dr][c+dc]);
                end
            end
        end
        return pix_t'(sum / 16);
    endfunction

    function automatic void compute_expected(input pix_t thr);
        int         d;
        kpt_entry_t e;
        exp_q.delete();
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                d = int'(img[r][c]) - int'(blur_pixel(r, c));
                if (d < 0) begin
                    d = -d;
                end
                if (d > int'(thr) && exp_q.size() < KPT_DEPTH) begin
                    e.row = row_addr_t'(r);
                    e.col = col_t'(c);
                    exp_q.push_back(e);
                end
            end
        end
    endfunction

    task automatic check_count(input count_t actual, input count_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: kpt_count expected %0d, got %0d", $time, expected, actual);
            $display("Some tests failed");
            $fatal(1, "keypoint count mismatch");
        end
    endtask

    task automatic check_entry(input int idx, input kpt_entry_t actual, input kpt_entry_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: entry %0d expected row %0d col %0d, got row %0d col %0d",
                     $time, idx, expected.row, expected.col, actual.row, actual.col);
            $display("Some tests failed");
            $fatal(1, "keypoint entry mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic fill_image(input logic full);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                img[r][c] = full ? pix_t'(random_bits(PIX_W)) : sparse_pixel();
            end
        end
    endtask

    task automatic load_image();
        for (int r = 0; r < IMG_ROWS; r++) begin
            @(posedge clk);
            #1;
            img_we   = 1'b1;
            img_addr = row_addr_t'(r);
            img_din  = pack_row(r);
        end
        @(posedge clk);
        #1;
        img_we = 1'b0;
    endtask

    // junk rows and a stray start while the core runs
    task automatic overwrite_during_busy();
        for (int k = 0; k < IMG_ROWS; k++) begin
            @(posedge clk);
            #1;
            img_we   = 1'b1;
            img_addr = row_addr_t'(k);
            img_din  = random_row();
            start    = (k == 3);
        end
        @(posedge clk);
        #1;
        img_we = 1'b0;
        start  = 1'b0;
    endtask

    task automatic run_detection(input pix_t thr, input logic disturb);
        compute_expected(thr);
        @(posedge clk);
        #1;
        threshold = thr;
        start     = 1'b1;
        check_req = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_flag("busy after start", busy, 1'b1);
        if (disturb) begin
            overwrite_during_busy();
        end
        wait (!check_req);   // readout finished
    endtask

    initial begin : compare_results
        kpt_rd_addr = '0;
        forever begin
            wait (check_req);
            @(negedge clk);
            while (done !== 1'b1) begin
                @(negedge clk);
            end
            check_count(kpt_count, count_t'(exp_q.size()));
            for (int i = 0; i < exp_q.size(); i++) begin
                @(posedge clk);
                #1;
                kpt_rd_addr = kaddr_t'(i);
                @(posedge clk);
                @(negedge clk);
                check_entry(i, kpt_dout, exp_q[i]);
            end
            check_req = 1'b0;
        end
    end

    initial begin : watchdog
        #(LIMIT * CLK_PERIOD);
        $display("Timeout: done never arrived within %0d cycles", LIMIT);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        rst_n      = 1'b0;
        start      = 1'b0;
        threshold  = '0;
        img_we     = 1'b0;
        img_addr   = '0;
        img_din    = '0;
        check_req  = 1'b0;
        lfsr_state = LFSR_SEED;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("busy after reset", busy, 1'b0);
            check_flag("done after reset", done, 1'b0);
        end

        fill_image(1'b0);
        load_image();
        run_detection(8'd20, 1'b0);
        run_detection(8'd255, 1'b0);   // same image, nothing passes
        check_count(kpt_count, count_t'(0));

        fill_image(1'b1);
        load_image();
        run_detection(8'd0, 1'b0);
        check_count(kpt_count, count_t'(KPT_DEPTH));   // saturated

        fill_image(1'b0);
        load_image();
        run_detection(8'd12, 1'b1);

        fill_image(1'b0);
        load_image();
        run_detection(8'd16, 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule
